/* project.f */
+incdir+include
verilog/cpu_pkg.sv
verilog/alu8.sv
verilog/register_file.sv
verilog/bus_sequencer.sv
verilog/instruction_control.sv
verilog/cpu_core.sv
verification/cpu_assertions.sv
verification/tb_cpu.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the CPU testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f --top-module tb_cpu \
	--Mdir obj_dir -o tb_cpu_sim > build.log 2>&1
if [ $? -ne 0 ]; then
	echo "Verilator build failed, see build.log"
	exit 1
fi

./obj_dir/tb_cpu_sim > sim.log 2>&1
if [ $? -ne 0 ]; then
	echo "Simulation exited with an error, see sim.log"
	exit 1
fi

if grep -qx "TEST RESULT: PASS" sim.log; then
	echo "Simulation passed"
	exit 0
fi

echo "Simulation failed, see sim.log"
exit 1

/* verification/cpu_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_assertions (
	input logic                            clk,
	input logic                            reset,
	input logic [cpu_pkg::addr_width-1:0] adr,
	input logic                            read,
	input logic                            write,
	input logic                            ddrv
);

	// Only one strobe at a time
	assert property (@(posedge clk) disable iff (reset) !(read && write))
		else $error("read and write are high together");

	// A store always drives the data bus
	assert property (@(posedge clk) disable iff (reset) write |-> ddrv)
		else $error("write is high while ddrv is low");

	assert property (@(posedge clk) disable iff (reset) (read || write) |-> $stable(adr))
		else $error("adr changed during a strobe");

	// The strobes come out of reset low
	assert property (@(posedge clk) $past(reset) |-> (!read && !write))
		else $error("a strobe is high right after reset");

endmodule

bind cpu_core cpu_assertions asrt0 (
	.clk   (clk),
	.reset (reset),
	.adr   (adr),
	.read  (read),
	.write (write),
	.ddrv  (ddrv)
);

`default_nettype wire

/* include/cpu_ref_model.svh */
`ifndef CPU_REF_MODEL_SVH
`define CPU_REF_MODEL_SVH

// Instruction-level model of the kept LR35902 subset
// Its memory is a copy of the testbench memory taken before reset is released
logic [7:0] m_mem [0:65535];
logic [7:0] m_reg [0:7];
logic m_z;
logic m_n;
logic m_h;
logic m_c;

// Expected reads in bus order, with a marker for opcode fetches
int exp_rd_addr[$];
bit exp_rd_op[$];
int exp_gap[$];
logic [3:0] exp_flags[$];
int exp_wr_addr[$];
int exp_wr_data[$];

// The gap is the clock count since the previous opcode fetch
// The flags are the ZNHC nibble left behind by the previous instruction
task automatic expect_read(input logic [15:0] a, input bit is_op, input int gap);
	exp_rd_addr.push_back(int'(a));
	exp_rd_op.push_back(is_op);
	if (is_op)
	begin
		exp_gap.push_back(gap);
		exp_flags.push_back({m_z, m_n, m_h, m_c});
	end
endtask

// Accumulator operations in opcode order ADD ADC SUB SBC AND XOR OR CP
task automatic model_alu(input logic [2:0] op, input logic [7:0] x, input logic [7:0] y,
		output logic [7:0] res);
	int full;
	int low;
	int cin;
	cin = ((op == 3'd1 || op == 3'd3) && m_c) ? 1 : 0;
	full = 0;
	case (op)
	3'd0, 3'd1:
	begin
		full = int'(x) + int'(y) + cin;
		low = int'(x[3:0]) + int'(y[3:0]) + cin;
		m_h = low > 15;
		m_c = full > 255;
		m_n = 1'b0;
	end
	3'd2, 3'd3, 3'd7:
	begin
		full = int'(x) - int'(y) - cin;
		m_h = int'(x[3:0]) < int'(y[3:0]) + cin;
		m_c = full < 0;
		m_n = 1'b1;
	end
	default:
	begin
		// Logic operations clear C and N, only AND sets H
		if (op == 3'd4)
			full = int'(x & y);
		else if (op == 3'd5)
			full = int'(x ^ y);
		else
			full = int'(x | y);
		m_h = op == 3'd4;
		m_c = 1'b0;
		m_n = 1'b0;
	end
	endcase
	res = 8'(full);
	m_z = res == 8'h00;
endtask

// INC and DEC never touch the carry
task automatic model_incdec(input bit dec, inout logic [7:0] v);
	m_h = dec ? (v[3:0] == 4'h0) : (v[3:0] == 4'hf);
	v = dec ? v - 8'd1 : v + 8'd1;
	m_z = v == 8'h00;
	m_n = dec;
endtask

// Runs from reset until the final self-loop has executed three times
task automatic model_run(input logic [15:0] loop_pc);
	logic [15:0] pc;
	logic [15:0] hl;
	logic [7:0] op;
	logic [7:0] imm;
	logic [7:0] hi;
	logic [7:0] val;
	int mc;
	int loops;
	bit take;
	for (int a = 0; a < 65536; a++)
		m_mem[a] = mem[a];
	for (int r = 0; r < 8; r++)
		m_reg[r] = 8'h00;
	{m_z, m_n, m_h, m_c} = 4'b0000;
	pc = cpu_pkg::reset_pc;
	mc = 0;
	loops = 0;
	while (loops < 3)
	begin
		if (pc == loop_pc)
			loops++;
		op = m_mem[pc];
		expect_read(pc, 1'b1, 4 * mc);
		pc = pc + 16'd1;
		hl = {m_reg[4], m_reg[5]};
		mc = 1;
		if (op[7:6] == 2'b01 && op != 8'h76)
		begin
			if (op[2:0] == 3'd6)
			begin
				expect_read(hl, 1'b0, 0);
				m_reg[op[5:3]] = m_mem[hl];
				mc = 2;
			end
			else if (op[5:3] == 3'd6)
			begin
				exp_wr_addr.push_back(int'(hl));
				exp_wr_data.push_back(int'(m_reg[op[2:0]]));
				m_mem[hl] = m_reg[op[2:0]];
				mc = 2;
			end
			else
				m_reg[op[5:3]] = m_reg[op[2:0]];
		end
		else if (op[7:6] == 2'b10 || (op[7:6] == 2'b11 && op[2:0] == 3'd6))
		begin
			if (op[7:6] == 2'b11)
			begin
				expect_read(pc, 1'b0, 0);
				val = m_mem[pc];
				pc = pc + 16'd1;
				mc = 2;
			end
			else if (op[2:0] == 3'd6)
			begin
				expect_read(hl, 1'b0, 0);
				val = m_mem[hl];
				mc = 2;
			end
			else
				val = m_reg[op[2:0]];
			model_alu(op[5:3], m_reg[7], val, imm);
			// CP keeps A
			if (op[5:3] != 3'd7)
				m_reg[7] = imm;
		end
		else if (op[7:6] == 2'b00 && op[2:0] == 3'd6 && op[5:3] != 3'd6)
		begin
			expect_read(pc, 1'b0, 0);
			m_reg[op[5:3]] = m_mem[pc];
			pc = pc + 16'd1;
			mc = 2;
		end
		else if (op[7:6] == 2'b00 && op[2:1] == 2'b10 && op[5:3] != 3'd6)
		begin
			val = m_reg[op[5:3]];
			model_incdec(op[0], val);
			m_reg[op[5:3]] = val;
		end
		else if (op == 8'hc3)
		begin
			expect_read(pc, 1'b0, 0);
			expect_read(pc + 16'd1, 1'b0, 0);
			imm = m_mem[pc];
			hi = m_mem[pc + 16'd1];
			pc = {hi, imm};
			mc = 4;
		end
		else if (op == 8'h18 || op == 8'h20 || op == 8'h28 || op == 8'h30 || op == 8'h38)
		begin
			expect_read(pc, 1'b0, 0);
			imm = m_mem[pc];
			pc = pc + 16'd1;
			case (op)
			8'h20: take = !m_z;
			8'h28: take = m_z;
			8'h30: take = !m_c;
			8'h38: take = m_c;
			default: take = 1'b1;
			endcase
			mc = take ? 3 : 2;
			if (take)
				pc = pc + {{8{imm[7]}}, imm};
		end
	end
endtask

`endif

/* verification/tb_cpu.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_cpu;

	logic clk;
	logic reset;
	logic [15:0] adr;
	logic [7:0] dout;
	logic [7:0] data;
	logic ddrv;
	logic read;
	logic write;

	logic [7:0] mem [0:65535];
	integer seed;
	int mismatch_count;
	int timeout_count;
	int clk_count;
	int last_fetch_clk;
	bit first_read;
	logic read_q;
	logic [15:0] loop_pc;

	cpu_core dut0 (
		.clk   (clk),
		.reset (reset),
		.adr   (adr),
		.dout  (dout),
		.ddrv  (ddrv),
		.read  (read),
		.write (write),
		.data  (data)
	);

	`include "cpu_ref_model.svh"

	initial clk = 1'b0;
	always #10 clk = ~clk;

	// Zero-wait memory answers as long as read is high
	assign data = read ? mem[adr] : 8'h00;

	task automatic check_value(input int actual, input int expected, input string what);
		if (actual !== expected)
		begin
			$display("Fail at %0t ns: %s, got %0h, expected %0h", $time, what, actual, expected);
			mismatch_count++;
		end
	endtask

	function automatic int rand_below(input int n);
		int v;
		v = $random(seed);
		return (v & 32'h7fffffff) % n;
	endfunction

	// Destinations skip H and L so that HL stays in the data page
	function automatic logic [2:0] pick_dst();
		int v;
		v = rand_below(5);
		return (v == 4) ? 3'd7 : 3'(v);
	endfunction

	task automatic put_byte(inout logic [15:0] a, input logic [7:0] b);
		mem[a] = b;
		a = a + 16'd1;
	endtask

	// Builds a forward-only program that ends in a JR -2 self-loop
	task automatic build_program(input int n_inst);
		logic [15:0] a;
		logic [15:0] inst_addr [0:127];
		logic [15:0] fix_pos [0:127];
		int fix_target [0:127];
		bit fix_rel [0:127];
		int nfix;
		int t;
		logic [2:0] dst;
		logic [2:0] src;
		logic [15:0] off;
		for (int i = 0; i < 65536; i++)
			mem[i] = 8'(i) ^ 8'(i >> 8) ^ 8'h5a;
		a = 16'h0000;
		nfix = 0;
		inst_addr[0] = a;
		put_byte(a, 8'h26);
		put_byte(a, 8'h80 | 8'(rand_below(128)));
		inst_addr[1] = a;
		put_byte(a, 8'h2e);
		put_byte(a, 8'(rand_below(256)));
		for (int i = 2; i < n_inst - 1; i++)
		begin
			inst_addr[i] = a;
			src = 3'(rand_below(8));
			case (rand_below(11))
			0, 1:
			begin
				// L may move inside the page, H never changes
				dst = (rand_below(6) == 5) ? 3'd5 : pick_dst();
				put_byte(a, {2'b00, dst, 3'b110});
				put_byte(a, 8'(rand_below(256)));
			end
			2: put_byte(a, {2'b01, pick_dst(), src});
			3: put_byte(a, {2'b01, 3'b110, (src == 3'd6) ? 3'd7 : src});
			4: put_byte(a, {2'b10, 3'(rand_below(8)), src});
			5:
			begin
				put_byte(a, {2'b11, 3'(rand_below(8)), 3'b110});
				put_byte(a, 8'(rand_below(256)));
			end
			6: put_byte(a, {2'b00, pick_dst(), 2'b10, 1'(rand_below(2))});
			7, 8:
			begin
				t = rand_below(5);
				put_byte(a, (t == 0) ? 8'h18 : {3'b001, 2'(t - 1), 3'b000});
				fix_pos[nfix] = a;
				fix_rel[nfix] = 1'b1;
				// Targets past the end of the program land on the self-loop
				t = i + 1 + rand_below(3);
				fix_target[nfix] = (t < n_inst) ? t : n_inst - 1;
				nfix++;
				put_byte(a, 8'h00);
			end
			9:
			begin
				put_byte(a, 8'hc3);
				fix_pos[nfix] = a;
				fix_rel[nfix] = 1'b0;
				fix_target[nfix] = (i + 2 < n_inst) ? i + 2 : n_inst - 1;
				nfix++;
				put_byte(a, 8'h00);
				put_byte(a, 8'h00);
			end
			default: put_byte(a, rand_below(2) == 0 ? 8'h77 : 8'h00);
			endcase
		end
		inst_addr[n_inst - 1] = a;
		loop_pc = a;
		put_byte(a, 8'h18);
		put_byte(a, 8'hfe);
		// Jump targets are only known once every instruction has its address
		for (int j = 0; j < nfix; j++)
		begin
			if (fix_rel[j])
			begin
				off = inst_addr[fix_target[j]] - (fix_pos[j] + 16'd1);
				mem[fix_pos[j]] = off[7:0];
			end
			else
			begin
				mem[fix_pos[j]] = inst_addr[fix_target[j]][7:0];
				mem[fix_pos[j] + 16'd1] = inst_addr[fix_target[j]][15:8];
			end
		end
	endtask

	// Bus monitor that checks reads, fetch spacing, flags and stores
	always @(posedge clk)
	begin
		clk_count++;
		if (!reset && read && !read_q && exp_rd_addr.size() > 0)
		begin
			if (first_read)
				check_value(int'(adr), int'(cpu_pkg::reset_pc), "first fetch address after reset");
			first_read = 1'b0;
			check_value(int'(adr), exp_rd_addr.pop_front(), "read address");
			// The core lets go of the data bus for every read
			check_value(int'(ddrv), 0, "ddrv during a read");
			if (exp_rd_op.pop_front())
			begin
				// The previous instruction has already written its flags
				check_value(int'(dut0.regs0.regs.f), int'(exp_flags.pop_front()),
					"flags at opcode fetch");
				if (last_fetch_clk >= 0)
					check_value(clk_count - last_fetch_clk, exp_gap.pop_front(),
						"clocks between opcode fetches");
				else
					void'(exp_gap.pop_front());
				last_fetch_clk = clk_count;
			end
		end
		if (!reset && write)
		begin
			mem[adr] = dout;
			if (exp_wr_addr.size() > 0)
			begin
				check_value(int'(adr), exp_wr_addr.pop_front(), "write address");
				check_value(int'(dout), exp_wr_data.pop_front(), "write data");
			end
			else
			begin
				$display("Unexpected bus write at %0t ns to address %h", $time, adr);
				mismatch_count++;
			end
		end
		read_q = read;
	end

	initial
	begin
		int wait_cycles;
		seed = 39;
		mismatch_count = 0;
		timeout_count = 0;
		clk_count = 0;
		last_fetch_clk = -1;
		first_read = 1'b1;
		read_q = 1'b0;
		reset = 1'b1;
		build_program(70);
		model_run(loop_pc);
		repeat (2) @(posedge clk);
		#1 reset = 1'b0;
		wait_cycles = 0;
		while (exp_rd_addr.size() > 0 && wait_cycles < 20000)
		begin
			@(posedge clk);
			wait_cycles++;
		end
		if (exp_rd_addr.size() > 0)
		begin
			$display("Timeout: the DUT stopped before all expected bus reads were seen");
			timeout_count++;
		end
		check_value(exp_wr_addr.size(), 0, "expected writes never seen");
		$display("Errors: %0d mismatches, %0d timeouts", mismatch_count, timeout_count);
		if (mismatch_count + timeout_count == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* verilog/alu8.sv */
`timescale 1ns/1ps
`default_nettype none

module alu8 (
	input  cpu_pkg::alu_op_t                op,
	input  logic [cpu_pkg::data_width-1:0] a,
	input  logic [cpu_pkg::data_width-1:0] arg,
	input  cpu_pkg::flags_t                 flags_in,
	output logic [cpu_pkg::data_width-1:0] result,
	output cpu_pkg::flags_t                 flags_out
);

	logic carry_in;
	logic [4:0] nib;
	logic [8:0] wide;
	logic n_out;

	always_comb
	begin
		carry_in = 1'b0;
		nib = 5'd0;
		wide = 9'd0;
		n_out = 1'b0;
		case (op)
		cpu_pkg::alu_add, cpu_pkg::alu_adc:
		begin
			carry_in = (op == cpu_pkg::alu_adc) && flags_in.c;
			// Bit 4 of the low nibble sum is the half carry
			nib = 5'(a[3:0]) + 5'(arg[3:0]) + 5'(carry_in);
			wide = 9'(a) + 9'(arg) + 9'(carry_in);
		end
		cpu_pkg::alu_sub, cpu_pkg::alu_sbc, cpu_pkg::alu_cp:
		begin
			carry_in = (op == cpu_pkg::alu_sbc) && flags_in.c;
			// A borrow wraps into the extra top bit
			nib = 5'(a[3:0]) - 5'(arg[3:0]) - 5'(carry_in);
			wide = 9'(a) - 9'(arg) - 9'(carry_in);
			n_out = 1'b1;
		end
		cpu_pkg::alu_and: wide = {1'b0, a & arg};
		cpu_pkg::alu_xor: wide = {1'b0, a ^ arg};
		cpu_pkg::alu_or: wide = {1'b0, a | arg};
		cpu_pkg::alu_inc:
		begin
			nib = 5'(arg[3:0]) + 5'd1;
			wide = 9'(arg) + 9'd1;
		end
		cpu_pkg::alu_dec:
		begin
			nib = 5'(arg[3:0]) - 5'd1;
			wide = 9'(arg) - 9'd1;
			n_out = 1'b1;
		end
		default: wide = 9'd0;
		endcase
	end

	assign result = wide[7:0];

	// AND forces H, OR and XOR clear it, INC and DEC pass the old carry through
	always_comb
	begin
		flags_out.z = wide[7:0] == 8'd0;
		flags_out.n = n_out;
		flags_out.h = (op == cpu_pkg::alu_and) ? 1'b1 : nib[4];
		flags_out.c = (op == cpu_pkg::alu_inc || op == cpu_pkg::alu_dec) ? flags_in.c : wide[8];
	end

endmodule

`default_nettype wire

/* verilog/bus_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module bus_sequencer (
	input  logic                            clk,
	input  logic                            reset,
	input  cpu_pkg::bus_cmd_t               next_cmd,
	input  logic [cpu_pkg::data_width-1:0] data,
	output logic                            mc_last,
	output logic [cpu_pkg::data_width-1:0] rdata,
	output logic [cpu_pkg::addr_width-1:0] adr,
	output logic [cpu_pkg::data_width-1:0] dout,
	output logic                            ddrv,
	output logic                            read,
	output logic                            write
);

	logic [1:0] cycle;
	cpu_pkg::bus_cmd_t cmd;
	logic cmd_is_read;

	// Fetches and operand reads use the same strobe sequence
	assign cmd_is_read = (cmd.kind == cpu_pkg::bus_fetch) || (cmd.kind == cpu_pkg::bus_read);
	assign mc_last = cycle == 2'(cpu_pkg::cycles_per_mc - 1);

	// Cycle counter, command latch and strobes
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			cycle <= 2'd0;
			// Reset starts the core on an opcode fetch at the reset vector
			cmd   <= '{kind: cpu_pkg::bus_fetch, addr: cpu_pkg::reset_pc, wdata: '0};
			read  <= 1'b0;
			write <= 1'b0;
			ddrv  <= 1'b0;
		end
		else
		begin
			cycle <= cycle + 2'd1;
			if (mc_last)
				cmd <= next_cmd;
			case (cycle)
			2'd0:
			begin
				// The data bus is only driven for a store
				if (cmd_is_read)
					ddrv <= 1'b0;
				else if (cmd.kind == cpu_pkg::bus_write)
					ddrv <= 1'b1;
			end
			2'd1:
			begin
				read  <= cmd_is_read;
				write <= cmd.kind == cpu_pkg::bus_write;
			end
			2'd2:
				write <= 1'b0;
			default:
				read <= 1'b0;
			endcase
		end
	end

	// Address, store data and captured read data
	always_ff @(posedge clk)
	begin
		if (cycle == 2'd0 && cmd.kind != cpu_pkg::bus_idle)
			adr <= cmd.addr;
		if (cycle == 2'd0 && cmd.kind == cpu_pkg::bus_write)
			dout <= cmd.wdata;
		// Memory answers while read is high in cycle 2
		if (cycle == 2'd2 && cmd_is_read)
			rdata <= data;
	end

endmodule

`default_nettype wire

/* verilog/cpu_core.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_core (
	input  logic                            clk,
	input  logic                            reset,
	output logic [cpu_pkg::addr_width-1:0] adr,
	output logic [cpu_pkg::data_width-1:0] dout,
	output logic                            ddrv,
	output logic                            read,
	output logic                            write,
	input  logic [cpu_pkg::data_width-1:0] data
);

	// Handshake between the bus sequencer and the instruction control
	cpu_pkg::bus_cmd_t next_cmd;
	logic mc_last;
	logic [cpu_pkg::data_width-1:0] rdata;

	// Register file ports
	cpu_pkg::reg_set_t regs;
	cpu_pkg::reg_write_t reg_wr;
	cpu_pkg::flag_write_t flag_wr;

	// ALU operands and results
	cpu_pkg::alu_op_t alu_op;
	logic [cpu_pkg::data_width-1:0] alu_arg;
	logic [cpu_pkg::data_width-1:0] alu_result;
	cpu_pkg::flags_t alu_flags;

	bus_sequencer seq0 (
		.clk      (clk),
		.reset    (reset),
		.next_cmd (next_cmd),
		.data     (data),
		.mc_last  (mc_last),
		.rdata    (rdata),
		.adr      (adr),
		.dout     (dout),
		.ddrv     (ddrv),
		.read     (read),
		.write    (write)
	);

	instruction_control ctrl0 (
		.clk        (clk),
		.reset      (reset),
		.mc_last    (mc_last),
		.rdata      (rdata),
		.regs       (regs),
		.alu_result (alu_result),
		.alu_flags  (alu_flags),
		.next_cmd   (next_cmd),
		.reg_wr     (reg_wr),
		.flag_wr    (flag_wr),
		.alu_op     (alu_op),
		.alu_arg    (alu_arg)
	);

	register_file regs0 (
		.clk     (clk),
		.reset   (reset),
		.reg_wr  (reg_wr),
		.flag_wr (flag_wr),
		.regs    (regs)
	);

	// The accumulator and the live flags feed the ALU directly
	alu8 alu0 (
		.op        (alu_op),
		.a         (regs.a),
		.arg       (alu_arg),
		.flags_in  (regs.f),
		.result    (alu_result),
		.flags_out (alu_flags)
	);

endmodule

`default_nettype wire

/* verilog/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

	// Data bytes and addresses are fixed by the LR35902 architecture
	localparam int data_width = 8;
	localparam int addr_width = 16;

	// Every machine cycle on the external bus spans this many clocks
	localparam int cycles_per_mc = 4;

	// Bit positions inside the flag nibble, Z on top and C at the bottom
	localparam int flag_z = 3;
	localparam int flag_n = 2;
	localparam int flag_h = 1;
	localparam int flag_c = 0;

	// The first opcode fetch after reset reads this address
	localparam logic [addr_width-1:0] reset_pc = 16'h0000;

	// Register codes as they appear in bits 5:3 and 2:0 of an opcode
	typedef enum logic [2:0] {
		reg_b  = 3'd0,
		reg_c  = 3'd1,
		reg_d  = 3'd2,
		reg_e  = 3'd3,
		reg_h  = 3'd4,
		reg_l  = 3'd5,
		mem_hl = 3'd6,
		reg_a  = 3'd7
	} reg_sel_t;

	// The first eight values follow opcode bits 5:3 of the ALU group
	typedef enum logic [3:0] {
		alu_add = 4'd0,
		alu_adc = 4'd1,
		alu_sub = 4'd2,
		alu_sbc = 4'd3,
		alu_and = 4'd4,
		alu_xor = 4'd5,
		alu_or  = 4'd6,
		alu_cp  = 4'd7,
		alu_inc = 4'd8,
		alu_dec = 4'd9
	} alu_op_t;

	typedef enum logic [1:0] {
		bus_idle  = 2'd0,
		bus_fetch = 2'd1,
		bus_read  = 2'd2,
		bus_write = 2'd3
	} bus_kind_t;

	typedef enum logic [2:0] {
		st_fetch     = 3'd0,
		st_imm_lo    = 3'd1,
		st_imm_hi    = 3'd2,
		st_ind_read  = 3'd3,
		st_ind_write = 3'd4,
		st_jump      = 3'd5
	} ctrl_state_t;

	typedef struct packed {
		logic z;
		logic n;
		logic h;
		logic c;
	} flags_t;

	// What the bus sequencer runs in the following machine cycle
	typedef struct packed {
		bus_kind_t             kind;
		logic [addr_width-1:0] addr;
		logic [data_width-1:0] wdata;
	} bus_cmd_t;

	typedef struct packed {
		logic                  en;
		reg_sel_t              target;
		logic [data_width-1:0] data;
	} reg_write_t;

	// Only the flags with a set mask bit change
	typedef struct packed {
		logic [3:0] mask;
		flags_t     value;
	} flag_write_t;

	typedef struct packed {
		logic [data_width-1:0] b;
		logic [data_width-1:0] c;
		logic [data_width-1:0] d;
		logic [data_width-1:0] e;
		logic [data_width-1:0] h;
		logic [data_width-1:0] l;
		logic [data_width-1:0] a;
		flags_t                f;
	} reg_set_t;

endpackage

`default_nettype wire

/* verilog/instruction_control.sv */
`timescale 1ns/1ps
`default_nettype none

module instruction_control (
	input  logic                            clk,
	input  logic                            reset,
	input  logic                            mc_last,
	input  logic [cpu_pkg::data_width-1:0] rdata,
	input  cpu_pkg::reg_set_t               regs,
	input  logic [cpu_pkg::data_width-1:0] alu_result,
	input  cpu_pkg::flags_t                 alu_flags,
	output cpu_pkg::bus_cmd_t               next_cmd,
	output cpu_pkg::reg_write_t             reg_wr,
	output cpu_pkg::flag_write_t            flag_wr,
	output cpu_pkg::alu_op_t                alu_op,
	output logic [cpu_pkg::data_width-1:0] alu_arg
);

	cpu_pkg::ctrl_state_t state;
	cpu_pkg::ctrl_state_t state_next;
	logic [15:0] pc;
	logic [15:0] pc_next;
	logic [15:0] pc_inc;
	logic [15:0] hl;
	logic [15:0] jump_target;
	logic [7:0] op;
	logic [7:0] imm_lo;
	logic [7:0] imm_hi;
	logic [7:0] cur_op;
	cpu_pkg::reg_sel_t dst;
	cpu_pkg::reg_sel_t src;
	cpu_pkg::reg_sel_t wr_target;
	logic is_ld_rr;
	logic is_ld_imm;
	logic is_alu_r;
	logic is_alu_imm;
	logic is_incdec;
	logic is_jp;
	logic is_jr;
	logic jr_taken;
	logic alu_commit;
	logic wr_en;
	logic [7:0] wr_data;
	logic [3:0] alu_mask;

	// Reads a register by its opcode code, where (HL) stands for the bus byte
	function automatic logic [7:0] reg_value(input cpu_pkg::reg_set_t r,
			input cpu_pkg::reg_sel_t sel, input logic [7:0] mem);
		logic [7:0] v;
		case (sel)
		cpu_pkg::reg_b: v = r.b;
		cpu_pkg::reg_c: v = r.c;
		cpu_pkg::reg_d: v = r.d;
		cpu_pkg::reg_e: v = r.e;
		cpu_pkg::reg_h: v = r.h;
		cpu_pkg::reg_l: v = r.l;
		cpu_pkg::reg_a: v = r.a;
		default: v = mem;
		endcase
		return v;
	endfunction

	// During the fetch cycle the opcode is still on the read data lines
	assign cur_op = (state == cpu_pkg::st_fetch) ? rdata : op;
	assign dst = cpu_pkg::reg_sel_t'(cur_op[5:3]);
	assign src = cpu_pkg::reg_sel_t'(cur_op[2:0]);

	// Opcode groups of the kept subset, 0x76 and all others fall through as NOP
	assign is_ld_rr = (cur_op[7:6] == 2'b01) && (cur_op != 8'h76);
	assign is_ld_imm = (cur_op[7:6] == 2'b00) && (src == cpu_pkg::mem_hl) && (dst != cpu_pkg::mem_hl);
	assign is_alu_r = cur_op[7:6] == 2'b10;
	assign is_alu_imm = (cur_op[7:6] == 2'b11) && (src == cpu_pkg::mem_hl);
	assign is_incdec = (cur_op[7:6] == 2'b00) && (cur_op[2:1] == 2'b10) && (dst != cpu_pkg::mem_hl);
	assign is_jp = cur_op == 8'hc3;
	assign is_jr = (cur_op == 8'h18) || ((cur_op[7:5] == 3'b001) && (cur_op[2:0] == 3'b000));

	// Bit 4 picks C over Z and bit 3 gives the flag value that takes the branch
	assign jr_taken = (cur_op == 8'h18) ||
		((cur_op[4] ? regs.f[cpu_pkg::flag_c] : regs.f[cpu_pkg::flag_z]) == cur_op[3]);

	assign hl = {regs.h, regs.l};
	assign pc_inc = pc + 16'd1;
	assign jump_target = is_jp ? {imm_hi, imm_lo} : pc + {{8{imm_lo[7]}}, imm_lo};

	assign alu_op = is_incdec ? (cur_op[0] ? cpu_pkg::alu_dec : cpu_pkg::alu_inc)
		: cpu_pkg::alu_op_t'({1'b0, cur_op[5:3]});
	// Register operands are only read in the fetch cycle, later ones come off the bus
	assign alu_arg = (state == cpu_pkg::st_fetch) ? reg_value(regs, is_incdec ? dst : src, rdata)
		: rdata;

	// INC and DEC leave the carry alone
	always_comb
	begin
		alu_mask = 4'b0000;
		alu_mask[cpu_pkg::flag_z] = 1'b1;
		alu_mask[cpu_pkg::flag_n] = 1'b1;
		alu_mask[cpu_pkg::flag_h] = 1'b1;
		alu_mask[cpu_pkg::flag_c] = !is_incdec;
	end

	always_comb
	begin
		state_next = state;
		pc_next = pc;
		next_cmd = '{kind: cpu_pkg::bus_fetch, addr: pc_inc, wdata: '0};
		alu_commit = 1'b0;
		wr_en = 1'b0;
		wr_target = dst;
		wr_data = rdata;
		case (state)
		cpu_pkg::st_fetch:
		begin
			pc_next = pc_inc;
			if (is_ld_imm || is_alu_imm || is_jr || is_jp)
				state_next = cpu_pkg::st_imm_lo;
			else if ((is_ld_rr || is_alu_r) && src == cpu_pkg::mem_hl)
			begin
				state_next = cpu_pkg::st_ind_read;
				next_cmd = '{kind: cpu_pkg::bus_read, addr: hl, wdata: '0};
			end
			else if (is_ld_rr && dst == cpu_pkg::mem_hl)
			begin
				state_next = cpu_pkg::st_ind_write;
				next_cmd = '{kind: cpu_pkg::bus_write, addr: hl, wdata: reg_value(regs, src, rdata)};
			end
			else if (is_ld_rr)
			begin
				wr_en = 1'b1;
				wr_data = reg_value(regs, src, rdata);
			end
			else
				alu_commit = is_alu_r || is_incdec;
		end
		cpu_pkg::st_imm_lo:
		begin
			pc_next = pc_inc;
			state_next = cpu_pkg::st_fetch;
			if (is_jp)
				state_next = cpu_pkg::st_imm_hi;
			else if (is_jr && jr_taken)
			begin
				// A taken branch spends one idle machine cycle on the new PC
				state_next = cpu_pkg::st_jump;
				next_cmd.kind = cpu_pkg::bus_idle;
			end
			else if (is_ld_imm)
				wr_en = 1'b1;
			else
				alu_commit = is_alu_imm;
		end
		cpu_pkg::st_imm_hi:
		begin
			pc_next = pc_inc;
			state_next = cpu_pkg::st_jump;
			next_cmd.kind = cpu_pkg::bus_idle;
		end
		cpu_pkg::st_ind_read:
		begin
			// PC already points past the opcode
			state_next = cpu_pkg::st_fetch;
			next_cmd.addr = pc;
			wr_en = is_ld_rr;
			alu_commit = is_alu_r;
		end
		cpu_pkg::st_ind_write:
		begin
			state_next = cpu_pkg::st_fetch;
			next_cmd.addr = pc;
		end
		cpu_pkg::st_jump:
		begin
			state_next = cpu_pkg::st_fetch;
			pc_next = jump_target;
			next_cmd.addr = jump_target;
		end
		default:
			state_next = cpu_pkg::st_fetch;
		endcase
		// CP only updates the flags
		if (alu_commit)
		begin
			wr_en = alu_op != cpu_pkg::alu_cp;
			wr_target = is_incdec ? dst : cpu_pkg::reg_a;
			wr_data = alu_result;
		end
	end

	// Writes land on the same edge that closes the machine cycle
	assign reg_wr = '{en: wr_en && mc_last, target: wr_target, data: wr_data};
	assign flag_wr = '{mask: (alu_commit && mc_last) ? alu_mask : 4'b0000, value: alu_flags};

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= cpu_pkg::st_fetch;
			pc <= cpu_pkg::reset_pc;
		end
		else if (mc_last)
		begin
			state <= state_next;
			pc <= pc_next;
		end
	end

	// Opcode and immediates are kept for the later cycles of an instruction
	always_ff @(posedge clk)
	begin
		if (mc_last && state == cpu_pkg::st_fetch)
			op <= rdata;
		if (mc_last && state == cpu_pkg::st_imm_lo)
			imm_lo <= rdata;
		if (mc_last && state == cpu_pkg::st_imm_hi)
			imm_hi <= rdata;
	end

endmodule

`default_nettype wire

/* verilog/register_file.sv */
`timescale 1ns/1ps
`default_nettype none

module register_file (
	input  logic                 clk,
	input  logic                 reset,
	input  cpu_pkg::reg_write_t  reg_wr,
	input  cpu_pkg::flag_write_t flag_wr,
	output cpu_pkg::reg_set_t    regs
);

	cpu_pkg::flags_t f_next;

	// Flags outside the mask keep their old value
	assign f_next = cpu_pkg::flags_t'((regs.f & ~flag_wr.mask) | (flag_wr.value & flag_wr.mask));

	always_ff @(posedge clk)
	begin
		if (reset)
			regs <= '0;
		else
		begin
			if (reg_wr.en)
			begin
				case (reg_wr.target)
				cpu_pkg::reg_b: regs.b <= reg_wr.data;
				cpu_pkg::reg_c: regs.c <= reg_wr.data;
				cpu_pkg::reg_d: regs.d <= reg_wr.data;
				cpu_pkg::reg_e: regs.e <= reg_wr.data;
				cpu_pkg::reg_h: regs.h <= reg_wr.data;
				cpu_pkg::reg_l: regs.l <= reg_wr.data;
				cpu_pkg::reg_a: regs.a <= reg_wr.data;
				// Memory targets go out on the bus instead
				default: ;
				endcase
			end
			regs.f <= f_next;
		end
	end

endmodule

`default_nettype wire
